// File: verilog/axis_out_cfg_pkg.sv
// ##############################
// axis_out configuration
// widths and depths of the byte stream data path and FIFO
// ##############################

`default_nettype none

package axis_out_cfg_pkg;

   // system side word and stream side byte
   localparam int DATA_W = 32;
   localparam int TDATA_W = 8;
   localparam int LANES = DATA_W / TDATA_W;

   // fifo depth counted in bytes (32)
   localparam int FIFO_ADDR_W = 5;
   // each lane ram holds 8 words
   localparam int RAM_ADDR_W = FIFO_ADDR_W - $clog2(LANES);
   // level spans 0 up to the full depth
   localparam int LEVEL_W = FIFO_ADDR_W + 1;

endpackage

`default_nettype wire

// File: verilog/axis_out_csr_pkg.sv
// ##############################
// axis_out register map
// word addresses and status field positions
// ##############################

`default_nettype none

package axis_out_csr_pkg;

   localparam int CSR_ADDR_W = 4;

   localparam logic [CSR_ADDR_W-1:0] ADDR_SOFT_RESET = 4'd0;
   localparam logic [CSR_ADDR_W-1:0] ADDR_ENABLE = 4'd1;
   // mode 0 is cpu data port, 1 is input stream
   localparam logic [CSR_ADDR_W-1:0] ADDR_MODE = 4'd2;
   localparam logic [CSR_ADDR_W-1:0] ADDR_NWORDS = 4'd3;
   localparam logic [CSR_ADDR_W-1:0] ADDR_THRESHOLD = 4'd4;
   localparam logic [CSR_ADDR_W-1:0] ADDR_DATA = 4'd5;
   localparam logic [CSR_ADDR_W-1:0] ADDR_STATUS = 4'd6;

   // status register fields
   localparam int STATUS_EMPTY_BIT = 0;
   localparam int STATUS_FULL_BIT = 1;
   localparam int STATUS_LEVEL_LSB = 8;

endpackage

`default_nettype wire

// File: verilog/cdc_sync.sv
// ##############################
// cdc_sync
// two-flop synchronizer for any packed payload
// ##############################

`timescale 1ns/100ps
`default_nettype none

module cdc_sync #(
   parameter type sig_t = logic
) (
   input  logic clk_i,
   input  logic reset_i,
   input  sig_t d_i,
   output sig_t q_o
);

   // first stage may go metastable
   sig_t meta;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta <= '0;
         q_o  <= '0;
      end else begin
         meta <= d_i;
         q_o  <= meta;
      end
   end

endmodule

`default_nettype wire

// File: verilog/lane_ram.sv
// ##############################
// lane_ram
// dual-clock storage for one byte lane
// ##############################

`timescale 1ns/100ps
`default_nettype none

module lane_ram
   import axis_out_cfg_pkg::*;
(
   input  logic                  w_clk_i,
   input  logic                  w_en_i,
   input  logic [RAM_ADDR_W-1:0] w_addr_i,
   input  logic [   TDATA_W-1:0] w_data_i,
   input  logic                  r_clk_i,
   input  logic                  r_en_i,
   input  logic [RAM_ADDR_W-1:0] r_addr_i,
   output logic [   TDATA_W-1:0] r_data_o
);

   logic [TDATA_W-1:0] mem[2**RAM_ADDR_W];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read data appears one edge after the request
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: verilog/async_fifo.sv
// ##############################
// async_fifo
// word in, byte out, across two clocks
// ##############################

`timescale 1ns/100ps
`default_nettype none

module async_fifo
   import axis_out_cfg_pkg::*;
(
   input  logic                w_clk_i,
   input  logic                w_reset_i,
   input  logic                w_en_i,
   input  logic [  DATA_W-1:0] w_data_i,
   output logic                w_full_o,
   output logic                w_empty_o,
   output logic [ LEVEL_W-1:0] w_level_o,
   input  logic                r_clk_i,
   input  logic                r_reset_i,
   input  logic                r_en_i,
   output logic [ TDATA_W-1:0] r_data_o,
   output logic                r_empty_o
);

   // write pointer counts words, read pointer counts bytes
   logic [ RAM_ADDR_W:0] w_ptr;
   logic [ RAM_ADDR_W:0] w_ptr_nxt;
   logic [ RAM_ADDR_W:0] w_gray;
   logic [ RAM_ADDR_W:0] w_gray_r;
   logic [ RAM_ADDR_W:0] w_ptr_r;
   logic [FIFO_ADDR_W:0] r_ptr;
   logic [FIFO_ADDR_W:0] r_ptr_nxt;
   logic [FIFO_ADDR_W:0] r_gray;
   logic [FIFO_ADDR_W:0] r_gray_w;
   logic [FIFO_ADDR_W:0] r_ptr_w;
   logic [  LEVEL_W-1:0] w_level;
   logic                 w_push;
   logic                 r_pop;
   logic [FIFO_ADDR_W-RAM_ADDR_W-1:0] r_lane;
   logic [FIFO_ADDR_W-RAM_ADDR_W-1:0] r_lane_q;
   logic [    LANES-1:0] r_lane_en;
   logic [  TDATA_W-1:0] lane_data[LANES];

   // write side
   assign w_push    = w_en_i & ~w_full_o;
   assign w_ptr_nxt = w_ptr + 1'b1;

   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_ptr  <= '0;
         w_gray <= '0;
      end else if (w_push) begin
         w_ptr  <= w_ptr_nxt;
         w_gray <= w_ptr_nxt ^ (w_ptr_nxt >> 1);
      end
   end

   cdc_sync #(
      .sig_t(logic [FIFO_ADDR_W:0])
   ) u_rptr_sync (
      .clk_i  (w_clk_i),
      .reset_i(w_reset_i),
      .d_i    (r_gray),
      .q_o    (r_gray_w)
   );

   always_comb begin
      for (int i = 0; i <= FIFO_ADDR_W; i++) begin
         r_ptr_w[i] = ^(r_gray_w >> i);
      end
   end

   // word pointer scaled to bytes
   assign w_level   = {w_ptr, {(FIFO_ADDR_W - RAM_ADDR_W){1'b0}}} - r_ptr_w;
   assign w_level_o = w_level;
   assign w_empty_o = (w_level == '0);
   // no room left for a whole word
   assign w_full_o  = (w_level > LEVEL_W'(2**FIFO_ADDR_W - LANES));

   // read side
   cdc_sync #(
      .sig_t(logic [RAM_ADDR_W:0])
   ) u_wptr_sync (
      .clk_i  (r_clk_i),
      .reset_i(r_reset_i),
      .d_i    (w_gray),
      .q_o    (w_gray_r)
   );

   always_comb begin
      for (int i = 0; i <= RAM_ADDR_W; i++) begin
         w_ptr_r[i] = ^(w_gray_r >> i);
      end
   end

   assign r_empty_o = (r_ptr == {w_ptr_r, {(FIFO_ADDR_W - RAM_ADDR_W){1'b0}}});
   assign r_pop     = r_en_i & ~r_empty_o;
   assign r_ptr_nxt = r_ptr + 1'b1;
   // low byte pointer bits pick the lane
   assign r_lane    = r_ptr[FIFO_ADDR_W-RAM_ADDR_W-1:0];
   assign r_lane_en = r_pop ? (LANES'(1) << r_lane) : '0;

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_ptr    <= '0;
         r_gray   <= '0;
         r_lane_q <= '0;
      end else if (r_pop) begin
         r_ptr    <= r_ptr_nxt;
         r_gray   <= r_ptr_nxt ^ (r_ptr_nxt >> 1);
         r_lane_q <= r_lane;
      end
   end

   for (genvar p = 0; p < LANES; p++) begin : g_lane
      lane_ram u_ram (
         .w_clk_i (w_clk_i),
         .w_en_i  (w_push),
         .w_addr_i(w_ptr[RAM_ADDR_W-1:0]),
         .w_data_i(w_data_i[p*TDATA_W+:TDATA_W]),
         .r_clk_i (r_clk_i),
         .r_en_i  (r_lane_en[p]),
         .r_addr_i(r_ptr[FIFO_ADDR_W-1:FIFO_ADDR_W-RAM_ADDR_W]),
         .r_data_o(lane_data[p])
      );
   end

   assign r_data_o = lane_data[r_lane_q];

endmodule

`default_nettype wire

// File: verilog/axis_out_csrs.sv
// ##############################
// axis_out_csrs
// control registers, data port and fifo write select
// ##############################

`timescale 1ns/100ps
`default_nettype none

module axis_out_csrs
   import axis_out_cfg_pkg::*, axis_out_csr_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  csr_valid_i,
   input  logic                  csr_write_i,
   input  logic [CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [    DATA_W-1:0] csr_wdata_i,
   input  logic [     LANES-1:0] csr_wstrb_i,
   output logic [    DATA_W-1:0] csr_rdata_o,
   output logic                  csr_ready_o,
   input  logic                  sys_tvalid_i,
   input  logic [    DATA_W-1:0] sys_tdata_i,
   output logic                  sys_tready_o,
   input  logic                  fifo_full_i,
   input  logic                  fifo_empty_i,
   input  logic [   LEVEL_W-1:0] fifo_level_i,
   output logic                  fifo_write_o,
   output logic [    DATA_W-1:0] fifo_wdata_o,
   output logic                  soft_reset_o,
   output logic                  enable_o,
   output logic [    DATA_W-1:0] nwords_o,
   output logic                  interrupt_o
);

   logic               wr_en;
   logic               data_wr;
   logic               mode;
   logic [LEVEL_W-1:0] threshold;

   // any strobe bit writes the whole register
   assign wr_en       = csr_valid_i & csr_write_i & (|csr_wstrb_i);
   // data writes wait for room in the fifo
   assign csr_ready_o = ~(csr_valid_i & csr_write_i & (csr_addr_i == ADDR_DATA) & fifo_full_i);
   assign data_wr     = wr_en & (csr_addr_i == ADDR_DATA) & ~fifo_full_i & ~mode;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         soft_reset_o <= 1'b0;
         enable_o     <= 1'b0;
         mode         <= 1'b0;
         nwords_o     <= '0;
         threshold    <= '0;
      end else if (wr_en) begin
         case (csr_addr_i)
            ADDR_SOFT_RESET: soft_reset_o <= csr_wdata_i[0];
            ADDR_ENABLE:     enable_o <= csr_wdata_i[0];
            ADDR_MODE:       mode <= csr_wdata_i[0];
            ADDR_NWORDS:     nwords_o <= csr_wdata_i;
            ADDR_THRESHOLD:  threshold <= csr_wdata_i[LEVEL_W-1:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         ADDR_SOFT_RESET: csr_rdata_o[0] = soft_reset_o;
         ADDR_ENABLE:     csr_rdata_o[0] = enable_o;
         ADDR_MODE:       csr_rdata_o[0] = mode;
         ADDR_NWORDS:     csr_rdata_o = nwords_o;
         ADDR_THRESHOLD:  csr_rdata_o[LEVEL_W-1:0] = threshold;
         ADDR_STATUS: begin
            csr_rdata_o[STATUS_EMPTY_BIT]                = fifo_empty_i;
            csr_rdata_o[STATUS_FULL_BIT]                 = fifo_full_i;
            csr_rdata_o[STATUS_LEVEL_LSB+:LEVEL_W]       = fifo_level_i;
         end
         default: ;
      endcase
   end

   // dma input only in stream mode
   assign sys_tready_o = ~fifo_full_i & enable_o & mode;

   assign fifo_write_o = enable_o & (mode ? (sys_tvalid_i & sys_tready_o) : data_wr);
   assign fifo_wdata_o = mode ? sys_tdata_i : csr_wdata_i;

   // low water mark
   assign interrupt_o  = (fifo_level_i <= threshold);

endmodule

`default_nettype wire

// File: verilog/axis_out.sv
// ##############################
// axis_out
// word fifo drained as a byte wide AXI-Stream
// ##############################

`timescale 1ns/100ps
`default_nettype none

module axis_out
   import axis_out_cfg_pkg::*, axis_out_csr_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  axis_clk_i,
   input  logic                  reset_i,
   input  logic                  csr_valid_i,
   input  logic                  csr_write_i,
   input  logic [CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [    DATA_W-1:0] csr_wdata_i,
   input  logic [     LANES-1:0] csr_wstrb_i,
   output logic [    DATA_W-1:0] csr_rdata_o,
   output logic                  csr_ready_o,
   input  logic                  sys_tvalid_i,
   input  logic [    DATA_W-1:0] sys_tdata_i,
   output logic                  sys_tready_o,
   output logic                  axis_tvalid_o,
   output logic [   TDATA_W-1:0] axis_tdata_o,
   output logic                  axis_tlast_o,
   input  logic                  axis_tready_i,
   output logic                  interrupt_o
);

   typedef enum logic {
      FETCH,
      PRESENT
   } rd_state_t;

   // system clock side
   logic               fifo_write;
   logic [ DATA_W-1:0] fifo_wdata;
   logic               fifo_full;
   logic               fifo_empty;
   logic [LEVEL_W-1:0] fifo_level;
   logic               soft_reset;
   logic               enable;
   logic [ DATA_W-1:0] nwords;
   logic               sys_reset;

   // stream clock side
   logic               axis_reset;
   logic               axis_enable;
   logic [ DATA_W-1:0] axis_nwords;
   logic               fifo_read;
   logic               axis_fifo_empty;
   logic [ DATA_W-1:0] byte_count;
   rd_state_t          state;
   rd_state_t          state_nxt;

   assign sys_reset = reset_i | soft_reset;

   axis_out_csrs u_csrs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .csr_valid_i (csr_valid_i),
      .csr_write_i (csr_write_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_wstrb_i (csr_wstrb_i),
      .csr_rdata_o (csr_rdata_o),
      .csr_ready_o (csr_ready_o),
      .sys_tvalid_i(sys_tvalid_i),
      .sys_tdata_i (sys_tdata_i),
      .sys_tready_o(sys_tready_o),
      .fifo_full_i (fifo_full),
      .fifo_empty_i(fifo_empty),
      .fifo_level_i(fifo_level),
      .fifo_write_o(fifo_write),
      .fifo_wdata_o(fifo_wdata),
      .soft_reset_o(soft_reset),
      .enable_o    (enable),
      .nwords_o    (nwords),
      .interrupt_o (interrupt_o)
   );

   // reset chain has no reset of its own
   cdc_sync #(.sig_t(logic)) u_reset_sync (
      .clk_i  (axis_clk_i),
      .reset_i(1'b0),
      .d_i    (sys_reset),
      .q_o    (axis_reset)
   );

   cdc_sync #(.sig_t(logic)) u_enable_sync (
      .clk_i  (axis_clk_i),
      .reset_i(axis_reset),
      .d_i    (enable),
      .q_o    (axis_enable)
   );

   // frame length is static while a frame runs
   cdc_sync #(.sig_t(logic [DATA_W-1:0])) u_nwords_sync (
      .clk_i  (axis_clk_i),
      .reset_i(axis_reset),
      .d_i    (nwords),
      .q_o    (axis_nwords)
   );

   async_fifo u_fifo (
      .w_clk_i  (clk_i),
      .w_reset_i(sys_reset),
      .w_en_i   (fifo_write),
      .w_data_i (fifo_wdata),
      .w_full_o (fifo_full),
      .w_empty_o(fifo_empty),
      .w_level_o(fifo_level),
      .r_clk_i  (axis_clk_i),
      .r_reset_i(axis_reset),
      .r_en_i   (fifo_read),
      .r_data_o (axis_tdata_o),
      .r_empty_o(axis_fifo_empty)
   );

   // read controller, frozen while enable is low
   always_comb begin
      state_nxt     = state;
      fifo_read     = 1'b0;
      axis_tvalid_o = 1'b0;
      case (state)
         FETCH: begin
            if (!axis_fifo_empty) begin
               fifo_read = axis_enable;
               state_nxt = PRESENT;
            end
         end
         default: begin
            if (byte_count <= axis_nwords) begin
               axis_tvalid_o = axis_enable;
               if (axis_tready_i) begin
                  if (axis_fifo_empty) begin
                     state_nxt = FETCH;
                  end else begin
                     fifo_read = axis_enable;
                  end
               end
            end else if (axis_fifo_empty) begin
               state_nxt = FETCH;
            end else begin
               // padding byte, dropped without valid
               fifo_read = axis_enable;
            end
         end
      endcase
   end

   always_ff @(posedge axis_clk_i) begin
      if (axis_reset) begin
         state <= FETCH;
      end else if (axis_enable) begin
         state <= state_nxt;
      end
   end

   // count of bytes taken from the fifo this frame
   always_ff @(posedge axis_clk_i) begin
      if (axis_reset) begin
         byte_count <= '0;
      end else if (fifo_read) begin
         byte_count <= byte_count + 1'b1;
      end
   end

   assign axis_tlast_o = axis_tvalid_o & (byte_count == axis_nwords);

endmodule

`default_nettype wire

// File: tests/tb_axis_out.sv
// ##############################
// tb_axis_out
// testbench for the word to byte stream output peripheral
// ##############################

`timescale 1ns/100ps
`default_nettype none

module tb_axis_out
   import axis_out_cfg_pkg::*, axis_out_csr_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   // words written over all tests, rejected ones included
   localparam int TOTAL_WORDS = 37;
   localparam int TIMEOUT_NS = 4 * TOTAL_WORDS * 40 * CLK_PERIOD + 2000;

   logic                  clk_i;
   logic                  axis_clk_i;
   logic                  reset_i;
   logic                  csr_valid_i;
   logic                  csr_write_i;
   logic [CSR_ADDR_W-1:0] csr_addr_i;
   logic [    DATA_W-1:0] csr_wdata_i;
   logic [     LANES-1:0] csr_wstrb_i;
   logic [    DATA_W-1:0] csr_rdata_o;
   logic                  csr_ready_o;
   logic                  sys_tvalid_i;
   logic [    DATA_W-1:0] sys_tdata_i;
   logic                  sys_tready_o;
   logic                  axis_tvalid_o;
   logic [   TDATA_W-1:0] axis_tdata_o;
   logic                  axis_tlast_o;
   logic                  axis_tready_i;
   logic                  interrupt_o;

   int         seed = 98;
   int         error_count = 0;
   int         byte_num = 0;
   int         sw_nwords = 0;
   logic       sw_enable = 1'b0;
   logic       sw_mode = 1'b0;
   logic       rand_ready = 1'b0;
   logic       ready_level = 1'b1;
   // expected bytes as {kept, last, data}
   logic [9:0] exp_q[$];
   logic [9:0] exp_entry;
   logic       holding = 1'b0;
   logic [7:0] held_data;
   logic       held_last;

   axis_out UUT (
      .clk_i        (clk_i),
      .axis_clk_i   (axis_clk_i),
      .reset_i      (reset_i),
      .csr_valid_i  (csr_valid_i),
      .csr_write_i  (csr_write_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_wstrb_i  (csr_wstrb_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_ready_o  (csr_ready_o),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i),
      .interrupt_o  (interrupt_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // stream clock lags by 10 ns
   initial begin
      axis_clk_i = 1'b0;
      #10;
      forever #(CLK_PERIOD / 2) axis_clk_i = ~axis_clk_i;
   end

   // byte n of the frame, padding beyond the frame length is not kept
   function automatic logic [9:0] ref_byte(input logic [DATA_W-1:0] word, input int lane,
                                           input int num, input int frame_len);
      logic [7:0] data;
      data = word[lane*TDATA_W+:TDATA_W];
      return {num <= frame_len, num == frame_len, data};
   endfunction

   task automatic note_failure(input string msg);
      $display("At %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected) else begin
         $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                  actual);
         error_count++;
      end
   endtask

   task automatic push_word(input logic [DATA_W-1:0] word);
      logic [9:0] entry;
      // lowest lane leaves first
      for (int lane = 0; lane < LANES; lane++) begin
         byte_num++;
         entry = ref_byte(word, lane, byte_num, sw_nwords);
         if (entry[9]) begin
            exp_q.push_back(entry);
         end
      end
   endtask

   task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(negedge clk_i);
      csr_valid_i = 1'b1;
      csr_write_i = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      csr_wstrb_i = '1;
      #1;
      // a data write stalls here while the FIFO is full
      while (!csr_ready_o) begin
         @(negedge clk_i);
         #1;
      end
      case (addr)
         ADDR_ENABLE: sw_enable = data[0];
         ADDR_MODE:   sw_mode = data[0];
         ADDR_NWORDS: sw_nwords = data;
         ADDR_DATA:   if (sw_enable && !sw_mode) push_word(data);
         default: ;
      endcase
      @(negedge clk_i);
      csr_valid_i = 1'b0;
      csr_write_i = 1'b0;
      csr_wstrb_i = '0;
   endtask

   task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(negedge clk_i);
      csr_valid_i = 1'b1;
      csr_write_i = 1'b0;
      csr_addr_i  = addr;
      #1;
      data = csr_rdata_o;
      @(negedge clk_i);
      csr_valid_i = 1'b0;
   endtask

   task automatic check_status(input logic exp_empty, input logic exp_full, input int exp_level);
      logic [DATA_W-1:0] status;
      csr_read(ADDR_STATUS, status);
      check_value("status empty", exp_empty, status[STATUS_EMPTY_BIT]);
      check_value("status full", exp_full, status[STATUS_FULL_BIT]);
      check_value("status level", exp_level, status[STATUS_LEVEL_LSB+:LEVEL_W]);
   endtask

   // frame counter restarts, registers keep their values
   task automatic soft_reset_pulse();
      csr_write(ADDR_SOFT_RESET, 1);
      repeat (4) @(negedge clk_i);
      csr_write(ADDR_SOFT_RESET, 0);
      repeat (8) @(negedge clk_i);
      byte_num = 0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
      // time for padding to leave and stray bytes to show up
      repeat (16) @(negedge clk_i);
      check_status(1'b1, 1'b0, 0);
   endtask

   always @(negedge axis_clk_i) begin
      if (rand_ready) begin
         axis_tready_i = 1'($random(seed));
      end else begin
         axis_tready_i = ready_level;
      end
   end

   // output monitor, samples mid cycle where the stream is stable
   always @(negedge axis_clk_i) begin
      #5;
      if (holding) begin
         assert (axis_tvalid_o) else note_failure("axis_tvalid_o dropped before a handshake");
         check_value("axis_tdata_o (held)", held_data, axis_tdata_o);
         check_value("axis_tlast_o (held)", held_last, axis_tlast_o);
      end
      if (axis_tvalid_o && axis_tready_i) begin
         assert (exp_q.size() > 0) else note_failure("a byte was sent that was not expected");
         if (exp_q.size() > 0) begin
            exp_entry = exp_q.pop_front();
            check_value("axis_tdata_o", exp_entry[7:0], axis_tdata_o);
            check_value("axis_tlast_o", exp_entry[8], axis_tlast_o);
         end
      end
      holding   = axis_tvalid_o && !axis_tready_i;
      held_data = axis_tdata_o;
      held_last = axis_tlast_o;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired: the output stream did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [DATA_W-1:0] word;
      int                accepted;
      reset_i      = 1'b1;
      csr_valid_i  = 1'b0;
      csr_write_i  = 1'b0;
      csr_addr_i   = '0;
      csr_wdata_i  = '0;
      csr_wstrb_i  = '0;
      sys_tvalid_i = 1'b0;
      sys_tdata_i  = '0;
      axis_tready_i = 1'b0;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      repeat (4) @(negedge clk_i);

      // out of reset the FIFO is empty and below the threshold
      check_status(1'b1, 1'b0, 0);
      check_value("interrupt_o", 1, interrupt_o);

      // whole words in cpu mode
      csr_write(ADDR_NWORDS, 12);
      csr_write(ADDR_MODE, 0);
      csr_write(ADDR_ENABLE, 1);
      repeat (3) csr_write(ADDR_DATA, $random(seed));
      wait_drain();

      // padding in the last word, then a fresh frame
      soft_reset_pulse();
      csr_write(ADDR_NWORDS, 10);
      repeat (3) csr_write(ADDR_DATA, $random(seed));
      wait_drain();
      soft_reset_pulse();
      repeat (3) csr_write(ADDR_DATA, $random(seed));
      wait_drain();

      // fill the FIFO under back-pressure
      soft_reset_pulse();
      csr_write(ADDR_NWORDS, 36);
      ready_level = 1'b0;
      repeat (8) csr_write(ADDR_DATA, $random(seed));
      repeat (10) @(negedge clk_i);
      // one byte already sits in the output stage
      check_status(1'b0, 1'b1, 31);
      word = $random(seed);
      fork
         csr_write(ADDR_DATA, word);
         begin
            @(negedge clk_i);
            #2;
            assert (!csr_ready_o) else note_failure("data write accepted while FIFO full");
            rand_ready = 1'b1;
         end
      join
      wait_drain();

      // input stream with random gaps
      soft_reset_pulse();
      csr_write(ADDR_ENABLE, 0);
      csr_write(ADDR_MODE, 1);
      #1;
      check_value("sys_tready_o", 0, sys_tready_o);
      csr_write(ADDR_NWORDS, 48);
      csr_write(ADDR_ENABLE, 1);
      // output held back until the full FIFO refuses a word
      rand_ready  = 1'b0;
      ready_level = 1'b0;
      accepted = 0;
      while (accepted < 12) begin
         @(negedge clk_i);
         sys_tvalid_i = 1'($random(seed));
         sys_tdata_i  = $random(seed);
         #1;
         if (sys_tvalid_i && sys_tready_o) begin
            push_word(sys_tdata_i);
            accepted++;
         end else if (sys_tvalid_i) begin
            // refused word, drain from here on
            rand_ready = 1'b1;
         end
      end
      @(negedge clk_i);
      sys_tvalid_i = 1'b0;
      wait_drain();
      rand_ready  = 1'b0;
      ready_level = 1'b1;
      csr_write(ADDR_MODE, 0);

      // interrupt against the threshold
      soft_reset_pulse();
      csr_write(ADDR_NWORDS, 12);
      csr_write(ADDR_THRESHOLD, 8);
      ready_level = 1'b0;
      repeat (2) csr_write(ADDR_DATA, $random(seed));
      repeat (10) @(negedge clk_i);
      check_status(1'b0, 1'b0, 7);
      check_value("interrupt_o", 1, interrupt_o);
      csr_write(ADDR_DATA, $random(seed));
      repeat (10) @(negedge clk_i);
      check_status(1'b0, 1'b0, 11);
      check_value("interrupt_o", 0, interrupt_o);
      ready_level = 1'b1;
      wait_drain();
      check_value("interrupt_o", 1, interrupt_o);

      // nothing moves while disabled
      soft_reset_pulse();
      csr_write(ADDR_ENABLE, 0);
      csr_write(ADDR_NWORDS, 8);
      repeat (2) csr_write(ADDR_DATA, $random(seed));
      repeat (10) @(negedge clk_i);
      check_status(1'b1, 1'b0, 0);
      check_value("axis_tvalid_o", 0, axis_tvalid_o);
      csr_write(ADDR_ENABLE, 1);
      repeat (2) csr_write(ADDR_DATA, $random(seed));
      wait_drain();

      $display("Checks done, errors: %0d", error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
verilog/axis_out_cfg_pkg.sv
verilog/axis_out_csr_pkg.sv
verilog/cdc_sync.sv
verilog/lane_ram.sv
verilog/async_fifo.sv
verilog/axis_out_csrs.sv
verilog/axis_out.sv
tests/tb_axis_out.sv

// File: run_sim.sh
#!/bin/sh
# build and run the axis_out testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_out \
   -f sim.f -o tb_axis_out

./obj_dir/tb_axis_out > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0
